// File: div_defines.svh
// width macros shared by the divide unit
// data width, destination tag width and iteration counter width

`ifndef DIV_DEFINES_SVH
`define DIV_DEFINES_SVH

// operand, quotient and remainder width
`define DIV_WIDTH 32

// destination register tag carried alongside a request
`define DIV_TAG_WIDTH 5

// must hold the values 0 to DIV_WIDTH - 1
`define DIV_COUNT_WIDTH 6

`endif

// File: div_pkg.sv
// types of the divide unit
// opcode and core state enums, request, operand, result and output structs

`include "div_defines.svh"

package div_pkg;

    // signed and unsigned quotient and remainder
    typedef enum logic [1:0] {
        op_div  = 2'b00,
        op_divu = 2'b01,
        op_mod  = 2'b10,
        op_modu = 2'b11
    } div_op_e;

    typedef enum logic [1:0] {
        st_idle    = 2'b00,
        st_iterate = 2'b01,
        st_fix     = 2'b10
    } core_state_e;

    // request as issued by the execute stage
    typedef struct packed {
        div_op_e                    op;
        logic [`DIV_TAG_WIDTH-1:0]  tag;
        logic [`DIV_WIDTH-1:0]      dividend;
        logic [`DIV_WIDTH-1:0]      divisor;
    } div_req_t;

    // magnitudes plus the sign corrections to apply at the end
    typedef struct packed {
        div_op_e                    op;
        logic [`DIV_TAG_WIDTH-1:0]  tag;
        logic [`DIV_WIDTH-1:0]      dividend_mag;
        logic [`DIV_WIDTH-1:0]      divisor_mag;
        logic                       neg_quotient;
        logic                       neg_remainder;
    } div_operands_t;

    typedef struct packed {
        div_op_e                    op;
        logic [`DIV_TAG_WIDTH-1:0]  tag;
        logic [`DIV_WIDTH-1:0]      quotient;
        logic [`DIV_WIDTH-1:0]      remainder;
    } div_result_t;

    typedef struct packed {
        logic [`DIV_TAG_WIDTH-1:0]  tag;
        logic [`DIV_WIDTH-1:0]      value;
    } div_out_t;

endpackage

// File: div_issue.sv
// input side of the divide unit
// captures a request strobe and converts the operands to magnitudes

`timescale 1ns/1ns

`include "div_defines.svh"

module div_issue
    import div_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          req_valid,
    input  div_req_t      req,
    input  logic          busy,
    output logic          issue_valid,
    output div_operands_t operands
);

    logic                  accept;
    logic                  signed_op;
    logic                  dividend_neg;
    logic                  divisor_neg;
    logic [`DIV_WIDTH-1:0] dividend_mag;
    logic [`DIV_WIDTH-1:0] divisor_mag;

    // requests that arrive while busy are dropped
    assign accept = req_valid && !busy;

    assign signed_op = (req.op == op_div) || (req.op == op_mod);

    assign dividend_neg = signed_op && req.dividend[`DIV_WIDTH-1];
    assign divisor_neg  = signed_op && req.divisor[`DIV_WIDTH-1];

    // the most negative value maps onto itself, read as 2^31 unsigned
    assign dividend_mag = dividend_neg ? (~req.dividend + 1'b1) : req.dividend;
    assign divisor_mag  = divisor_neg ? (~req.divisor + 1'b1) : req.divisor;

    always_ff @(posedge clk) begin
        if (rst) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            operands.op            <= req.op;
            operands.tag           <= req.tag;
            operands.dividend_mag  <= dividend_mag;
            operands.divisor_mag   <= divisor_mag;
            // quotient is negative when exactly one operand is
            operands.neg_quotient  <= dividend_neg ^ divisor_neg;
            // remainder follows the sign of the dividend
            operands.neg_remainder <= dividend_neg;
        end
    end

endmodule

// File: div_step.sv
// one restoring shift-subtract step of the divider

`timescale 1ns/1ns

`include "div_defines.svh"

module div_step (
    input  logic [2*`DIV_WIDTH-1:0] window,
    input  logic [`DIV_WIDTH-1:0]   divisor,
    output logic [2*`DIV_WIDTH-1:0] next_window,
    output logic                    quotient_bit
);

    logic [`DIV_WIDTH:0]   partial;
    logic [`DIV_WIDTH+1:0] trial;
    logic [2*`DIV_WIDTH-1:0] shifted;

    assign shifted = {window[2*`DIV_WIDTH-2:0], 1'b0};

    // upper half after the shift, keeping the bit that falls off the top
    assign partial = window[2*`DIV_WIDTH-1:`DIV_WIDTH-1];

    assign trial = {1'b0, partial} - {2'b00, divisor};

    // no borrow means the upper half was not smaller than the divisor
    assign quotient_bit = ~trial[`DIV_WIDTH+1];

    always_comb begin
        next_window = shifted;
        if (quotient_bit) begin
            next_window[2*`DIV_WIDTH-1:`DIV_WIDTH] = trial[`DIV_WIDTH-1:0];
        end
    end

endmodule

// File: div_core.sv
// iteration state machine of the divider
// holds remainder window, quotient and counter, and applies the sign fix

`timescale 1ns/1ns

`include "div_defines.svh"

module div_core
    import div_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          issue_valid,
    input  div_operands_t operands,
    output logic          idle,
    output logic          core_done,
    output div_result_t   result
);

    localparam logic [`DIV_COUNT_WIDTH-1:0] last_count =
        `DIV_COUNT_WIDTH'(`DIV_WIDTH - 1);

    core_state_e state;

    logic [`DIV_COUNT_WIDTH-1:0]  count;
    logic [2*`DIV_WIDTH-1:0]      window;
    logic [`DIV_WIDTH-1:0]        quotient;
    logic [`DIV_WIDTH-1:0]        divisor;
    logic [2*`DIV_WIDTH-1:0]      next_window;
    logic                         quotient_bit;
    logic [`DIV_WIDTH-1:0]        remainder;

    // carried request fields
    div_op_e                      op_r;
    logic [`DIV_TAG_WIDTH-1:0]    tag_r;
    logic                         neg_quotient_r;
    logic                         neg_remainder_r;

    div_step step_inst (
        .window       (window),
        .divisor      (divisor),
        .next_window  (next_window),
        .quotient_bit (quotient_bit)
    );

    assign idle      = (state == st_idle);
    assign remainder = window[2*`DIV_WIDTH-1:`DIV_WIDTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            count     <= '0;
            core_done <= 1'b0;
        end else begin
            core_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (issue_valid) begin
                        state <= st_iterate;
                        count <= '0;
                    end
                end
                st_iterate: begin
                    count <= count + 1'b1;
                    if (count == last_count) begin
                        state <= st_fix;
                    end
                end
                st_fix: begin
                    state     <= st_idle;
                    core_done <= 1'b1;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            st_idle: begin
                if (issue_valid) begin
                    window          <= {{`DIV_WIDTH{1'b0}}, operands.dividend_mag};
                    quotient        <= '0;
                    divisor         <= operands.divisor_mag;
                    op_r            <= operands.op;
                    tag_r           <= operands.tag;
                    neg_quotient_r  <= operands.neg_quotient;
                    neg_remainder_r <= operands.neg_remainder;
                end
            end
            st_iterate: begin
                window   <= next_window;
                quotient <= {quotient[`DIV_WIDTH-2:0], quotient_bit};
            end
            st_fix: begin
                result.op        <= op_r;
                result.tag       <= tag_r;
                result.quotient  <= neg_quotient_r ? (~quotient + 1'b1) : quotient;
                result.remainder <= neg_remainder_r ? (~remainder + 1'b1) : remainder;
            end
            default: begin
            end
        endcase
    end

endmodule

// File: div_writeback.sv
// output side of the divider
// selects quotient or remainder by opcode and registers it with its tag

`timescale 1ns/1ns

`include "div_defines.svh"

module div_writeback
    import div_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        core_done,
    input  div_result_t result,
    output logic        result_valid,
    output div_out_t    out
);

    logic [`DIV_WIDTH-1:0] selected;

    always_comb begin
        case (result.op)
            op_div, op_divu: begin
                selected = result.quotient;
            end
            op_mod, op_modu: begin
                selected = result.remainder;
            end
            default: begin
                selected = result.quotient;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= core_done;
        end
    end

    // out keeps its value until the next result
    always_ff @(posedge clk) begin
        if (core_done) begin
            out.tag   <= result.tag;
            out.value <= selected;
        end
    end

endmodule

// File: div_unit.sv
// top level of the iterative divide unit
// connects issue, core and writeback and derives busy

`timescale 1ns/1ns

module div_unit
    import div_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     req_valid,
    input  div_req_t req,
    output logic     busy,
    output logic     result_valid,
    output div_out_t result
);

    logic          issue_valid;
    div_operands_t operands;
    logic          core_idle;
    logic          core_done;
    div_result_t   core_result;

    // covers the cycle between capture and the core leaving idle
    assign busy = issue_valid || !core_idle;

    div_issue issue_inst (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req         (req),
        .busy        (busy),
        .issue_valid (issue_valid),
        .operands    (operands)
    );

    div_core core_inst (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .operands    (operands),
        .idle        (core_idle),
        .core_done   (core_done),
        .result      (core_result)
    );

    div_writeback writeback_inst (
        .clk          (clk),
        .rst          (rst),
        .core_done    (core_done),
        .result       (core_result),
        .result_valid (result_valid),
        .out          (result)
    );

endmodule

// File: div_unit_tb.sv
// testbench for the divide unit
// LFSR operands, reference model, directed and random divisions with checks

`timescale 1ns/1ns

`include "div_defines.svh"

module div_unit_tb
    import div_pkg::*;
();

    localparam int latency        = 35;
    localparam int timeout_cycles = 100;

    logic     clk;
    logic     rst;
    logic     req_valid;
    div_req_t req;
    logic     busy;
    logic     result_valid;
    div_out_t result;

    logic [15:0]               lfsr_state;
    logic [`DIV_TAG_WIDTH-1:0] next_tag;

    div_unit div_unit_inst (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req          (req),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("STATUS: FAIL");
        $fatal(1, "stopping after the first failed check");
    endtask

    task automatic value_error(string msg);
        $display("ERR at %0t ns: %s", $time, msg);
        stop_on_failure();
    endtask

    task automatic protocol_error(string msg);
        $display("%s at %0t ns", msg, $time);
        stop_on_failure();
    endtask

    // result_valid is a single-cycle pulse and never overlaps busy
    assert property (@(posedge clk) disable iff (rst) !(result_valid && $past(result_valid)))
        else protocol_error("result_valid stayed high for more than one cycle");

    assert property (@(posedge clk) disable iff (rst) result_valid |-> !busy)
        else protocol_error("busy was still high while result_valid was high");

    // taps 16, 14, 13 and 11 give a maximal length sequence
    function automatic logic lfsr_bit();
        logic feedback;
        feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], feedback};
        return feedback;
    endfunction

    function automatic logic [`DIV_WIDTH-1:0] random_bits(int count);
        logic [`DIV_WIDTH-1:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[`DIV_WIDTH-2:0], lfsr_bit()};
        end
        return value;
    endfunction

    // divide the magnitudes, then fix the signs and pick by opcode
    function automatic logic [`DIV_WIDTH-1:0] expected_value(div_op_e op,
                                                             logic [`DIV_WIDTH-1:0] a,
                                                             logic [`DIV_WIDTH-1:0] b);
        logic                  is_signed;
        logic                  a_neg;
        logic                  b_neg;
        logic [`DIV_WIDTH-1:0] a_mag;
        logic [`DIV_WIDTH-1:0] b_mag;
        logic [`DIV_WIDTH-1:0] q;
        logic [`DIV_WIDTH-1:0] r;
        is_signed = (op == op_div) || (op == op_mod);
        a_neg     = is_signed && a[`DIV_WIDTH-1];
        b_neg     = is_signed && b[`DIV_WIDTH-1];
        a_mag     = a_neg ? ('0 - a) : a;
        b_mag     = b_neg ? ('0 - b) : b;
        if (b_mag == '0) begin
            q = '1;
            r = a_mag;
        end else begin
            q = a_mag / b_mag;
            r = a_mag % b_mag;
        end
        if (a_neg != b_neg) begin
            q = '0 - q;
        end
        if (a_neg) begin
            r = '0 - r;
        end
        return ((op == op_div) || (op == op_divu)) ? q : r;
    endfunction

    task automatic wait_until_idle();
        int cycles;
        cycles = 0;
        while (busy) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > timeout_cycles) begin
                protocol_error("busy did not fall before timeout");
            end
        end
    endtask

    // with drop_test set a second request with another tag is issued while busy
    task automatic run_division(div_op_e op, logic [`DIV_WIDTH-1:0] a,
                                logic [`DIV_WIDTH-1:0] b, logic drop_test);
        logic [`DIV_WIDTH-1:0]     expected;
        logic [`DIV_TAG_WIDTH-1:0] req_tag;
        div_out_t                  first_result;
        int                        cycles;
        expected = expected_value(op, a, b);
        req_tag  = next_tag;
        next_tag = next_tag + 1'b1;
        wait_until_idle();
        req_valid    = 1'b1;
        req.op       = op;
        req.tag      = req_tag;
        req.dividend = a;
        req.divisor  = b;
        @(posedge clk);
        #2;
        req_valid = 1'b0;
        cycles    = 0;
        while (!result_valid) begin
            if (cycles < latency - 1) begin
                assert (busy) else value_error($sformatf("busy low %0d cycles after accept",
                                                         cycles));
            end
            req_valid = drop_test && (cycles == 10);
            if (req_valid) begin
                req.tag      = req_tag ^ {`DIV_TAG_WIDTH{1'b1}};
                req.dividend = a + 1'b1;
                req.divisor  = 32'd1;
            end
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > timeout_cycles) begin
                protocol_error("no result before timeout");
            end
        end
        assert (cycles == latency)
            else value_error($sformatf("result after %0d cycles, expected %0d", cycles, latency));
        assert (result.tag == req_tag)
            else value_error($sformatf("tag %0d, expected %0d", result.tag, req_tag));
        assert (result.value == expected)
            else value_error($sformatf("op %s a %h b %h gave %h, expected %h",
                                       op.name(), a, b, result.value, expected));
        first_result = result;
        @(posedge clk);
        #2;
        assert (!result_valid) else value_error("result_valid longer than one cycle");
        if (drop_test) begin
            repeat (40) begin
                @(posedge clk);
                #2;
                assert (!result_valid && !busy)
                    else value_error("request issued while busy was not dropped");
                assert (result == first_result)
                    else value_error("result changed without a new result_valid");
            end
        end
    endtask

    task automatic check_reset();
        repeat (16) begin
            @(posedge clk);
            #2;
            assert (!busy && !result_valid) else value_error("busy or result_valid in reset");
        end
        rst = 1'b0;
        repeat (4) begin
            @(posedge clk);
            #2;
            assert (!busy && !result_valid) else value_error("busy or result_valid after reset");
        end
    endtask

    task automatic check_unsigned();
        logic [`DIV_WIDTH-1:0] edges [3];
        logic [`DIV_WIDTH-1:0] a;
        logic [`DIV_WIDTH-1:0] b;
        edges = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff};
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                run_division(op_divu, edges[i], edges[j], 1'b0);
                run_division(op_modu, edges[i], edges[j], 1'b0);
            end
        end
        repeat (10) begin
            a = random_bits(32);
            b = random_bits(32) >> random_bits(5);
            run_division(op_divu, a, b, 1'b0);
            run_division(op_modu, a, b, 1'b0);
        end
    endtask

    task automatic check_signed();
        logic [`DIV_WIDTH-1:0] a_mag;
        logic [`DIV_WIDTH-1:0] b_mag;
        logic [`DIV_WIDTH-1:0] a;
        logic [`DIV_WIDTH-1:0] b;
        // s selects the dividend sign in bit 1 and the divisor sign in bit 0
        for (int s = 0; s < 4; s++) begin
            a = s[1] ? ('0 - 32'd7) : 32'd7;
            b = s[0] ? ('0 - 32'd2) : 32'd2;
            run_division(op_div, a, b, 1'b0);
            run_division(op_mod, a, b, 1'b0);
            repeat (4) begin
                a_mag = random_bits(31);
                b_mag = random_bits(31) >> random_bits(5);
                if (b_mag == '0) begin
                    b_mag = 32'd3;
                end
                a = s[1] ? ('0 - a_mag) : a_mag;
                b = s[0] ? ('0 - b_mag) : b_mag;
                run_division(op_div, a, b, 1'b0);
                run_division(op_mod, a, b, 1'b0);
            end
        end
        run_division(op_div, 32'h8000_0000, 32'hffff_ffff, 1'b0);
        run_division(op_mod, 32'h8000_0000, 32'hffff_ffff, 1'b0);
        run_division(op_div, 32'h8000_0000, 32'h0000_0001, 1'b0);
        run_division(op_mod, 32'h8000_0000, 32'h0000_0003, 1'b0);
    endtask

    task automatic check_zero_divisor();
        logic [`DIV_WIDTH-1:0] dividends [4];
        dividends = '{32'h0000_1234, 32'h8000_0000, 32'hffff_fffb, 32'h0000_0000};
        for (int i = 0; i < 4; i++) begin
            run_division(op_div, dividends[i], '0, 1'b0);
            run_division(op_divu, dividends[i], '0, 1'b0);
            run_division(op_mod, dividends[i], '0, 1'b0);
            run_division(op_modu, dividends[i], '0, 1'b0);
        end
    endtask

    initial begin
        rst        = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        lfsr_state = 16'd96;
        next_tag   = 5'd1;
        check_reset();
        check_unsigned();
        check_signed();
        check_zero_divisor();
        run_division(op_div, 32'd1000, '0 - 32'd7, 1'b1);
        run_division(op_divu, random_bits(32), random_bits(16), 1'b0);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: div_unit.f
+incdir+.
div_pkg.sv
div_issue.sv
div_step.sv
div_core.sv
div_writeback.sv
div_unit.sv
div_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the divide unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module div_unit_tb -f div_unit.f -o div_unit_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

output=$(./obj_dir/div_unit_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "STATUS: PASS"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
